// ==== rtl/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

    localparam int LSQ_DEPTH = 8;
    localparam int PTR_W = 3;
    // Wide enough for 16 in-flight ages by modular difference
    localparam int SEQ_W = 5;
    localparam int TAG_W = 6;

    typedef enum logic [1:0] {
        OP_LW,
        OP_LBU,
        OP_SW,
        OP_SB
    } lsq_op_e;

    typedef struct packed {
        lsq_op_e            op;
        logic [TAG_W-1:0]   dest;
        logic [TAG_W-1:0]   base_tag;
        logic [31:0]        base_val;
        logic               base_ready;
        logic [TAG_W-1:0]   data_tag;
        logic [31:0]        data_val;
        logic               data_ready;
        logic [11:0]        imm;
    } lsq_dispatch_t;

    typedef struct packed {
        lsq_dispatch_t      disp;
        logic [SEQ_W-1:0]   seq;
    } lsq_entry_t;

    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [31:0]        value;
    } cdb_t;

    function automatic logic op_is_store(lsq_op_e op);
        return (op == OP_SW) || (op == OP_SB);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/lsq_mem_pkg.sv ====
`default_nettype none

package lsq_mem_pkg;

    typedef struct packed {
        logic           read;
        logic [3:0]     wmask;
        logic [31:0]    addr;
        logic [31:0]    wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                       valid;
        logic [lsq_pkg::TAG_W-1:0]  dest;
        logic [31:0]                value;
    } lsq_result_t;

    // Wait states remember which kind goes first next time
    typedef enum logic [1:0] {
        WAIT_LOAD_PRI,
        WAIT_STORE_PRI,
        REQ_LOAD,
        REQ_STORE
    } lsq_arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/mem_op_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_op_queue
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        push,
    input  lsq_entry_t  push_entry,
    input  cdb_t        cdb,
    input  logic        pop,
    output logic        full,
    output logic        empty,
    output logic        head_ready,
    output lsq_entry_t  head
);

    lsq_entry_t         entries [LSQ_DEPTH];
    logic [PTR_W-1:0]   head_ptr;
    logic [PTR_W-1:0]   tail_ptr;
    logic [PTR_W:0]     count;
    logic [PTR_W-1:0]   rel_idx [LSQ_DEPTH];
    logic [LSQ_DEPTH-1:0] valid;

    // Capture any pending operand that the CDB is broadcasting
    function automatic lsq_entry_t wake(lsq_entry_t e, cdb_t c);
        lsq_entry_t r;
        r = e;
        if (c.valid && !e.disp.base_ready && e.disp.base_tag == c.tag) begin
            r.disp.base_val = c.value;
            r.disp.base_ready = 1'b1;
        end
        if (c.valid && !e.disp.data_ready && e.disp.data_tag == c.tag) begin
            r.disp.data_val = c.value;
            r.disp.data_ready = 1'b1;
        end
        return r;
    endfunction

    assign full = (count == (PTR_W+1)'(LSQ_DEPTH));
    assign empty = (count == '0);

    // Occupied slots lie between head and head + count
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            rel_idx[i] = PTR_W'(i) - head_ptr;
            valid[i] = ({1'b0, rel_idx[i]} < count);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (push && tail_ptr == PTR_W'(i)) begin
                entries[i] <= wake(push_entry, cdb);
            end else if (valid[i]) begin
                entries[i] <= wake(entries[i], cdb);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head = entries[head_ptr];

    // Stores also need their data operand
    assign head_ready = !empty && head.disp.base_ready &&
                        (!op_is_store(head.disp.op) || head.disp.data_ready);

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> !empty
    );

endmodule

`default_nettype wire

// ==== rtl/lsq_issue_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_issue_arbiter
    import lsq_pkg::*;
    import lsq_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  lsq_entry_t  load_head,
    input  logic        load_ready,
    input  logic        load_empty,
    input  lsq_entry_t  store_head,
    input  logic        store_ready,
    input  logic        store_empty,
    output logic        load_pop,
    output logic        store_pop,
    output logic        dmem_req_valid,
    output dmem_req_t   dmem_req,
    input  logic        dmem_resp,
    input  logic [31:0] dmem_rdata,
    output lsq_result_t result
);

    lsq_arb_state_e     state, next_state;
    logic               in_wait;
    logic [SEQ_W-1:0]   seq_diff;
    logic               load_elig, store_elig;
    logic [31:0]        load_addr, store_addr;
    dmem_req_t          load_req, store_req;
    logic [TAG_W-1:0]   req_dest;
    logic [1:0]         req_off;
    logic               req_lbu;
    logic               killed;
    logic               res_valid;
    logic [TAG_W-1:0]   res_dest;
    logic [31:0]        res_value;

    assign in_wait = (state == WAIT_LOAD_PRI) || (state == WAIT_STORE_PRI);

    // Load is older when the modular difference is negative
    assign seq_diff = load_head.seq - store_head.seq;
    assign load_elig = load_ready && (store_empty || seq_diff[SEQ_W-1]);
    assign store_elig = store_ready;

    assign load_addr = load_head.disp.base_val + {{20{load_head.disp.imm[11]}}, load_head.disp.imm};
    assign store_addr = store_head.disp.base_val +
                        {{20{store_head.disp.imm[11]}}, store_head.disp.imm};

    always_comb begin
        load_req.read = 1'b1;
        load_req.wmask = 4'b0000;
        load_req.addr = {load_addr[31:2], 2'b00};
        load_req.wdata = '0;
        store_req.read = 1'b0;
        store_req.addr = {store_addr[31:2], 2'b00};
        if (store_head.disp.op == OP_SB) begin
            store_req.wmask = 4'b0001 << store_addr[1:0];
            store_req.wdata = {24'b0, store_head.disp.data_val[7:0]} << (8 * store_addr[1:0]);
        end else begin
            store_req.wmask = 4'b1111;
            store_req.wdata = store_head.disp.data_val;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            WAIT_LOAD_PRI, WAIT_STORE_PRI: begin
                if (flush) begin
                    next_state = WAIT_LOAD_PRI;
                end else if (load_elig && store_elig) begin
                    next_state = (state == WAIT_LOAD_PRI) ? REQ_LOAD : REQ_STORE;
                end else if (load_elig) begin
                    next_state = REQ_LOAD;
                end else if (store_elig) begin
                    next_state = REQ_STORE;
                end
            end
            // Hand priority to the other kind afterwards
            REQ_LOAD: if (dmem_resp) next_state = WAIT_STORE_PRI;
            REQ_STORE: if (dmem_resp) next_state = WAIT_LOAD_PRI;
            default: next_state = WAIT_LOAD_PRI;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_LOAD_PRI;
            killed <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (dmem_resp) begin
                killed <= 1'b0;
            end else if (flush && !in_wait) begin
                killed <= 1'b1;
            end
            res_valid <= (state == REQ_LOAD) && dmem_resp && !killed && !flush;
        end
    end

    // Request is latched so a flush cannot disturb it mid-flight
    always_ff @(posedge clk) begin
        if (in_wait && next_state == REQ_LOAD) begin
            dmem_req <= load_req;
            req_dest <= load_head.disp.dest;
            req_off <= load_addr[1:0];
            req_lbu <= (load_head.disp.op == OP_LBU);
        end else if (in_wait && next_state == REQ_STORE) begin
            dmem_req <= store_req;
        end
        if (dmem_resp) begin
            res_dest <= req_dest;
            res_value <= req_lbu ? {24'b0, dmem_rdata[8*req_off +: 8]} : dmem_rdata;
        end
    end

    assign dmem_req_valid = !in_wait;
    assign load_pop = (state == REQ_LOAD) && dmem_resp && !killed;
    assign store_pop = (state == REQ_STORE) && dmem_resp && !killed;
    assign result = '{valid: res_valid, dest: res_dest, value: res_value};

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        dmem_req_valid && !dmem_resp |=> dmem_req_valid && $stable(dmem_req)
    );

    a_resp_in_req: assert property (
        @(posedge clk) disable iff (rst) dmem_resp |-> !in_wait
    );

endmodule

`default_nettype wire

// ==== rtl/load_store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_queue
    import lsq_pkg::*;
    import lsq_mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            dispatch_valid,
    input  lsq_dispatch_t   dispatch,
    output logic            dispatch_ready,
    input  cdb_t            cdb,
    output logic            dmem_req_valid,
    output dmem_req_t       dmem_req,
    input  logic            dmem_resp,
    input  logic [31:0]     dmem_rdata,
    output lsq_result_t     result
);

    logic               is_store;
    logic               accept;
    logic [SEQ_W-1:0]   seq;
    lsq_entry_t         new_entry;
    logic               load_full, load_empty, load_ready, load_pop;
    logic               store_full, store_empty, store_ready, store_pop;
    lsq_entry_t         load_head, store_head;

    assign is_store = op_is_store(dispatch.op);
    // Nothing enters while the queues are being flushed
    assign dispatch_ready = !flush && (is_store ? !store_full : !load_full);
    assign accept = dispatch_valid && dispatch_ready;
    assign new_entry = '{disp: dispatch, seq: seq};

    always_ff @(posedge clk) begin
        if (rst) begin
            seq <= '0;
        end else if (accept) begin
            seq <= seq + 1'b1;
        end
    end

    mem_op_queue load_q (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (accept && !is_store),
        .push_entry (new_entry),
        .cdb        (cdb),
        .pop        (load_pop),
        .full       (load_full),
        .empty      (load_empty),
        .head_ready (load_ready),
        .head       (load_head)
    );

    mem_op_queue store_q (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (accept && is_store),
        .push_entry (new_entry),
        .cdb        (cdb),
        .pop        (store_pop),
        .full       (store_full),
        .empty      (store_empty),
        .head_ready (store_ready),
        .head       (store_head)
    );

    lsq_issue_arbiter arbiter (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .load_head      (load_head),
        .load_ready     (load_ready),
        .load_empty     (load_empty),
        .store_head     (store_head),
        .store_ready    (store_ready),
        .store_empty    (store_empty),
        .load_pop       (load_pop),
        .store_pop      (store_pop),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_resp      (dmem_resp),
        .dmem_rdata     (dmem_rdata),
        .result         (result)
    );

endmodule

`default_nettype wire

// ==== bench/lsq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_checker
    import lsq_pkg::*;
    import lsq_mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            dispatch_valid,
    input  lsq_dispatch_t   dispatch,
    input  logic            dispatch_ready,
    input  cdb_t            cdb,
    input  logic            dmem_req_valid,
    input  dmem_req_t       dmem_req,
    input  logic            dmem_resp,
    input  lsq_result_t     result,
    output int              err_count,
    output int              pending
);

    int             seq_ctr;
    int             st_seq [$];
    int             ld_seq [$];
    lsq_dispatch_t  ld_disp [$];
    logic [5:0]     exp_dest [$];
    logic [31:0]    exp_val [$];
    logic [31:0]    exp_addr [$];
    logic [3:0]     exp_mask [$];
    logic [7:0]     sh_byte [1024];
    bit             sh_known [1024];
    bit             active;
    bit             pred_on;
    bit             pred_known;
    bit             pred_killed;
    bit             act_load;
    logic [5:0]     pred_dest;
    logic [31:0]    pred_val;
    int             test_num;
    int             test_errs;
    int             tests_run;
    int             tests_failed;

    task automatic flag_error(input string msg);
        $display("%s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic start_test(input int n);
        test_num = n;
        test_errs = 0;
    endtask

    task automatic expect_result(input logic [5:0] dest, input logic [31:0] value);
        exp_dest.push_back(dest);
        exp_val.push_back(value);
        pending = exp_dest.size() + exp_addr.size();
    endtask

    task automatic expect_request(input logic [31:0] addr, input logic [3:0] mask);
        exp_addr.push_back(addr);
        exp_mask.push_back(mask);
        pending = exp_dest.size() + exp_addr.size();
    endtask

    task automatic check_ready(input logic expected);
        if (dispatch_ready !== expected) begin
            flag_error($sformatf("MISMATCH dispatch_ready expected %h got %h",
                                 expected, dispatch_ready));
        end
    endtask

    task automatic end_test();
        if (exp_dest.size() != 0) begin
            flag_error($sformatf("Test %0d ended with %0d load results still missing",
                                 test_num, exp_dest.size()));
        end
        if (exp_addr.size() != 0) begin
            flag_error($sformatf("Test %0d ended with %0d memory requests never seen",
                                 test_num, exp_addr.size()));
        end
        exp_dest.delete();
        exp_val.delete();
        exp_addr.delete();
        exp_mask.delete();
        pending = 0;
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("Test %0d: failed with %0d errors", test_num, test_errs);
        end else begin
            $display("Test %0d: passed", test_num);
        end
    endtask

    task automatic report();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    endtask

    always @(posedge clk) begin
        lsq_dispatch_t  d;
        logic [31:0]    addr;
        logic [9:0]     idx;
        if (rst) begin
            seq_ctr = 0;
            st_seq.delete();
            ld_seq.delete();
            ld_disp.delete();
            active = 0;
            pred_on = 0;
        end else begin
            if (dispatch_valid && dispatch_ready) begin
                if (dispatch.op == OP_SW || dispatch.op == OP_SB) begin
                    st_seq.push_back(seq_ctr);
                end else begin
                    ld_seq.push_back(seq_ctr);
                    ld_disp.push_back(dispatch);
                end
                seq_ctr++;
            end
            // Base operand wakeup of the queued loads
            for (int i = 0; i < ld_disp.size(); i++) begin
                d = ld_disp[i];
                if (cdb.valid && !d.base_ready && d.base_tag == cdb.tag) begin
                    d.base_val = cdb.value;
                    d.base_ready = 1'b1;
                    ld_disp[i] = d;
                end
            end
            if (dmem_req_valid && !active) begin
                active = 1;
                act_load = dmem_req.read;
                if (exp_addr.size() != 0) begin
                    if (dmem_req.addr !== exp_addr[0]) begin
                        flag_error($sformatf("MISMATCH dmem_req.addr expected %h got %h",
                                             exp_addr[0], dmem_req.addr));
                    end
                    if (dmem_req.wmask !== exp_mask[0]) begin
                        flag_error($sformatf("MISMATCH dmem_req.wmask expected %h got %h",
                                             exp_mask[0], dmem_req.wmask));
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_mask.pop_front());
                end
                if (!dmem_req.read) begin
                    if (st_seq.size() == 0) begin
                        flag_error("Store request issued with no store queued");
                    end else begin
                        void'(st_seq.pop_front());
                    end
                end else if (ld_seq.size() == 0) begin
                    flag_error("Load request issued with no load queued");
                    pred_on = 0;
                end else begin
                    if (st_seq.size() != 0 && st_seq[0] < ld_seq[0]) begin
                        flag_error($sformatf("Load %0d requested before older store %0d",
                                             ld_seq[0], st_seq[0]));
                    end
                    void'(ld_seq.pop_front());
                    d = ld_disp.pop_front();
                    if (!d.base_ready) begin
                        flag_error("Load requested before its base operand arrived");
                    end
                    addr = d.base_val + {{20{d.imm[11]}}, d.imm};
                    if (dmem_req.addr !== {addr[31:2], 2'b00}) begin
                        flag_error($sformatf("MISMATCH dmem_req.addr expected %h got %h",
                                             {addr[31:2], 2'b00}, dmem_req.addr));
                    end
                    pred_on = 1;
                    pred_killed = 0;
                    pred_dest = d.dest;
                    idx = {addr[9:2], 2'b00};
                    if (d.op == OP_LBU) begin
                        pred_known = sh_known[addr[9:0]];
                        pred_val = {24'b0, sh_byte[addr[9:0]]};
                    end else begin
                        pred_known = sh_known[idx] && sh_known[idx + 1] &&
                                     sh_known[idx + 2] && sh_known[idx + 3];
                        pred_val = {sh_byte[idx + 3], sh_byte[idx + 2],
                                    sh_byte[idx + 1], sh_byte[idx]};
                    end
                end
            end
            if (flush) begin
                if (active && act_load) begin
                    pred_killed = 1;
                end
                st_seq.delete();
                ld_seq.delete();
                ld_disp.delete();
            end
            if (dmem_resp) begin
                if (!dmem_req.read) begin
                    idx = {dmem_req.addr[9:2], 2'b00};
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_req.wmask[b]) begin
                            sh_byte[idx + b] = dmem_req.wdata[8*b +: 8];
                            sh_known[idx + b] = 1;
                        end
                    end
                end
                active = 0;
            end
            if (result.valid) begin
                if (!pred_on) begin
                    flag_error("Load result seen with no load request");
                end else if (pred_killed) begin
                    flag_error("Load result returned for a flushed load");
                end else if (pred_known && result.value !== pred_val) begin
                    flag_error($sformatf("MISMATCH result.value expected %h got %h",
                                         pred_val, result.value));
                end
                pred_on = 0;
                if (exp_dest.size() == 0) begin
                    flag_error($sformatf("Unexpected load result for tag %h", result.dest));
                end else begin
                    if (result.dest !== exp_dest[0]) begin
                        flag_error($sformatf("MISMATCH result.dest expected %h got %h",
                                             exp_dest[0], result.dest));
                    end
                    if (result.value !== exp_val[0]) begin
                        flag_error($sformatf("MISMATCH result.value expected %h got %h",
                                             exp_val[0], result.value));
                    end
                    void'(exp_dest.pop_front());
                    void'(exp_val.pop_front());
                end
            end
            // Outstanding results and requests that a test still waits for
            pending = exp_dest.size() + exp_addr.size();
        end
    end

endmodule

`default_nettype wire

// ==== bench/lsq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_tb
    import lsq_pkg::*;
    import lsq_mem_pkg::*;
();

    logic           clk;
    logic           rst;
    logic           flush;
    logic           dispatch_valid;
    lsq_dispatch_t  dispatch;
    logic           dispatch_ready;
    cdb_t           cdb;
    logic           dmem_req_valid;
    dmem_req_t      dmem_req;
    logic           dmem_resp;
    logic [31:0]    dmem_rdata;
    lsq_result_t    result;
    logic [31:0]    mem [256];
    int             err_count;
    int             pending;
    int             cycles;
    int             limit;

    load_store_queue load_store_queue_i (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_resp      (dmem_resp),
        .dmem_rdata     (dmem_rdata),
        .result         (result)
    );

    lsq_checker monitor (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_resp      (dmem_resp),
        .result         (result),
        .err_count      (err_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Data memory with a random latency of 1 to 4 cycles
    initial begin
        int lat;
        int idx;
        void'($urandom(53875));
        dmem_resp = 1'b0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, 8'hc3};
        end
        forever begin
            @(negedge clk);
            if (!rst && dmem_req_valid) begin
                lat = $urandom % 4 + 1;
                repeat (lat - 1) @(negedge clk);
                idx = dmem_req.addr[9:2];
                if (dmem_req.read) begin
                    dmem_rdata = mem[idx];
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_req.wmask[b]) begin
                            mem[idx][8*b +: 8] = dmem_req.wdata[8*b +: 8];
                        end
                    end
                end
                dmem_resp = 1'b1;
                @(negedge clk);
                dmem_resp = 1'b0;
            end
        end
    end

    // Each command starts and ends on a falling edge
    task automatic send_dispatch(input lsq_dispatch_t d);
        dispatch = d;
        dispatch_valid = 1'b1;
        #1;
        while (!dispatch_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [5:0] tag, input logic [31:0] value);
        cdb = '{valid: 1'b1, tag: tag, value: value};
        @(negedge clk);
        cdb.valid = 1'b0;
    endtask

    initial begin
        int             fd;
        int             code;
        int             lines;
        int             tnum;
        int             cmd;
        string          line;
        logic [31:0]    a [9];
        lsq_dispatch_t  d;
        rst = 1'b1;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        cdb = '0;
        cycles = 0;
        limit = 0;
        fd = $fopen("bench/lsq_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/lsq_vectors.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            lines = 0;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    lines++;
                end
            end
            $fclose(fd);
            limit = lines * 20;
            fd = $fopen("bench/lsq_vectors.txt", "r");
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "T": begin
                        code = $fscanf(fd, "%d", tnum);
                        monitor.start_test(tnum);
                    end
                    "D": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", a[0], a[1], a[2],
                                       a[3], a[4], a[5], a[6], a[7], a[8]);
                        d.op = lsq_op_e'(a[0][1:0]);
                        d.dest = a[1][5:0];
                        d.base_tag = a[2][5:0];
                        d.base_val = a[3];
                        d.base_ready = a[4][0];
                        d.data_tag = a[5][5:0];
                        d.data_val = a[6];
                        d.data_ready = a[7][0];
                        d.imm = a[8][11:0];
                        send_dispatch(d);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h", a[0], a[1]);
                        broadcast(a[0][5:0], a[1]);
                    end
                    "F": begin
                        flush = 1'b1;
                        @(negedge clk);
                        flush = 1'b0;
                    end
                    "W": begin
                        code = $fscanf(fd, "%d", a[0]);
                        repeat (a[0]) @(negedge clk);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h", a[0], a[1]);
                        monitor.expect_result(a[0][5:0], a[1]);
                    end
                    "Q": begin
                        code = $fscanf(fd, "%h %h", a[0], a[1]);
                        monitor.expect_request(a[0], a[1][3:0]);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a[0], a[1]);
                        dispatch.op = lsq_op_e'(a[0][1:0]);
                        #1;
                        monitor.check_ready(a[1][0]);
                        @(negedge clk);
                    end
                    "X": begin
                        while (pending != 0 || dmem_req_valid) begin
                            @(negedge clk);
                        end
                        repeat (2) @(negedge clk);
                        monitor.end_test();
                    end
                    default: begin
                        code = $fgets(line, fd);
                    end
                endcase
            end
            $fclose(fd);
            monitor.report();
            if (err_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/lsq_vectors.txt ====
# T n test start | D op dest btag bval brdy dtag dval drdy imm | C tag value | F flush | W cycles
# E dest value expected result | Q addr wmask next request | R op ready expected | X test end
T 1
D 2 00 00 00000100 1 00 DEADBEEF 1 000
Q 00000100 f
D 0 05 00 00000100 1 00 00000000 1 000
Q 00000100 0
E 05 DEADBEEF
D 3 00 00 00000120 1 00 000000A7 1 002
Q 00000120 4
D 1 06 00 00000120 1 00 00000000 1 002
Q 00000120 0
E 06 000000A7
X
T 2
D 2 00 00 00000300 1 00 CAFEF00D 1 000
Q 00000300 f
D 2 00 00 00000200 1 0A 00000000 0 000
D 0 07 00 00000300 1 00 00000000 1 000
Q 00000200 f
Q 00000300 0
E 07 CAFEF00D
W 8
C 0A 12345678
X
T 3
D 0 08 11 00000000 0 00 00000000 1 004
W 6
Q 00000300 0
E 08 CAFEF00D
C 11 000002FC
X
T 4
D 0 10 20 00000000 0 00 00000000 1 000
D 0 11 20 00000000 0 00 00000000 1 000
D 0 12 20 00000000 0 00 00000000 1 000
D 0 13 20 00000000 0 00 00000000 1 000
D 0 14 20 00000000 0 00 00000000 1 000
D 0 15 20 00000000 0 00 00000000 1 000
D 0 16 20 00000000 0 00 00000000 1 000
D 0 17 20 00000000 0 00 00000000 1 000
R 0 0
R 2 1
D 2 00 00 00000400 1 00 11112222 1 000
Q 00000400 f
X
T 5
D 2 00 00 00000700 1 30 00000000 0 000
W 2
F
W 4
C 30 99999999
W 4
R 0 1
D 2 00 00 00000500 1 00 55AA55AA 1 000
Q 00000500 f
D 0 26 00 00000500 1 00 00000000 1 000
Q 00000500 0
E 26 55AA55AA
X
T 6
D 2 00 00 00000600 1 00 A1A1A1A1 1 000
D 0 21 00 00000600 1 00 00000000 1 000
D 2 00 00 00000604 1 00 B2B2B2B2 1 000
D 0 22 00 00000604 1 00 00000000 1 000
D 3 00 00 00000600 1 00 000000FF 1 001
D 0 23 00 00000600 1 00 00000000 1 000
D 1 24 00 00000604 1 00 00000000 1 003
E 21 A1A1A1A1
E 22 B2B2B2B2
E 23 A1A1FFA1
E 24 000000B2
X

// ==== compile.f ====
rtl/lsq_pkg.sv
rtl/lsq_mem_pkg.sv
rtl/mem_op_queue.sv
rtl/lsq_issue_arbiter.sv
rtl/load_store_queue.sv
bench/lsq_checker.sv
bench/lsq_tb.sv
